// File: logic/cpu_pkg.sv
////////////////////
// Shared types for the four-stage MIPS-32 subset core
// Only the kept opcodes and function codes are listed here
////////////////////
package cpu_pkg;

    localparam int XLEN = 32;

    // Three views of one instruction word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } insn_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_J = 6'h02, OP_BEQ = 6'h04, OP_BNE = 6'h05,
        OP_ADDI = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_ANDI = 6'h0c,
        OP_ORI = 6'h0d, OP_XORI = 6'h0e, OP_LUI = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03, FN_ADD = 6'h20,
        FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23, FN_AND = 6'h24,
        FN_OR = 6'h25, FN_XOR = 6'h26, FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    ////////////////////
    // Pipeline registers
    ////////////////////
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc_plus4;
        insn_t           insn;
    } if_id_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc_plus4;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [XLEN-1:0] rs_val;
        logic [XLEN-1:0] rt_val;
        logic [4:0]      dest;
        logic            wr_en;
        alu_op_e         alu_op;
        logic            use_imm;
        logic [XLEN-1:0] imm;
        logic [4:0]      shamt;
        logic            is_branch;
        logic            branch_ne;
        logic            is_jump;
        logic [XLEN-1:0] jump_target;
        logic            illegal;
    } id_ex_t;

    // Register write as seen at write-back and at the top-level trace port
    typedef struct packed {
        logic            valid;
        logic [4:0]      dest;
        logic [XLEN-1:0] value;
    } wb_trace_t;

    // Program-load write, addr counts words
    typedef struct packed {
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } load_req_t;

endpackage

// File: logic/run_ctrl.sv
////////////////////
// Load / run / halt sequencing of the core
// halt must be a single-cycle pulse from execute
////////////////////
module run_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic load_mode,
    input  logic halt,
    output logic running,
    output logic halted
);

    typedef enum logic [1:0] {ST_LOAD, ST_RUN, ST_HALT} state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            // Leave LOAD once the loader lets go
            ST_LOAD: state_nxt = load_mode ? ST_LOAD : ST_RUN;
            // Load mode is ignored while running
            ST_RUN:  state_nxt = halt ? ST_HALT : ST_RUN;
            ST_HALT: state_nxt = load_mode ? ST_LOAD : ST_HALT;
            default: state_nxt = ST_LOAD;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_LOAD;
        end else begin
            state <= state_nxt;
        end
    end

    // Memory writes are only let through while not running
    assign running = (state == ST_RUN);
    assign halted  = (state == ST_HALT);

endmodule

// File: logic/fetch_pc.sv
////////////////////
// PC and IF/ID register, no stall input
// PC sits at 0 whenever the core is not running
////////////////////
module fetch_pc
    import cpu_pkg::*;
#(
    parameter int IMEM_ADDR_W = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   running,
    input  logic                   redirect,
    input  logic [XLEN-1:0]        redirect_pc,
    input  insn_t                  fetch_insn,
    output logic [IMEM_ADDR_W-1:0] fetch_addr,
    output if_id_t                 if_id
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;

    assign pc_plus4 = pc + XLEN'(4);

    // Word index, upper PC bits fall off so fetch wraps in memory
    assign fetch_addr = pc[IMEM_ADDR_W+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            if_id <= '0;
        end else if (!running) begin
            // Parked at 0 so the first fetch after running rises is word 0
            pc          <= '0;
            if_id.valid <= 1'b0;
        end else if (redirect) begin
            // Taken branch or J in EX, the word fetched now is squashed
            pc          <= redirect_pc;
            if_id.valid <= 1'b0;
        end else begin
            pc    <= pc_plus4;
            if_id <= '{valid: 1'b1, pc_plus4: pc_plus4, insn: fetch_insn};
        end
    end

endmodule

// File: logic/insn_mem.sv
////////////////////
// Instruction memory, written only by the program loader
////////////////////
module insn_mem
    import cpu_pkg::*;
#(
    parameter int IMEM_ADDR_W = 8
) (
    input  logic                   clk,
    input  load_req_t              load,
    input  logic                   load_enable,
    input  logic [IMEM_ADDR_W-1:0] addr,
    output insn_t                  insn
);

    logic [XLEN-1:0] mem [2**IMEM_ADDR_W];

    // Loader address is truncated to the memory size
    always_ff @(posedge clk) begin
        if (load.we && load_enable) begin
            mem[load.addr[IMEM_ADDR_W-1:0]] <= load.data;
        end
    end

    // Asynchronous fetch read
    assign insn = mem[addr];

endmodule

// File: logic/decoder.sv
////////////////////
// Decode and ID/EX register
// Writes to r0 are turned into no-writes here
////////////////////
module decoder
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            running,
    input  logic            flush,
    input  if_id_t          if_id,
    input  logic [XLEN-1:0] rs_val,
    input  logic [XLEN-1:0] rt_val,
    output logic [4:0]      rs_num,
    output logic [4:0]      rt_num,
    output id_ex_t          id_ex
);

    id_ex_t dec;

    // Register numbers sit in the same bits for every format
    assign rs_num = if_id.insn.r.rs;
    assign rt_num = if_id.insn.r.rt;

    always_comb begin
        dec             = '0;
        dec.valid       = if_id.valid;
        dec.pc_plus4    = if_id.pc_plus4;
        dec.rs          = if_id.insn.r.rs;
        dec.rt          = if_id.insn.r.rt;
        dec.rs_val      = rs_val;
        dec.rt_val      = rt_val;
        dec.dest        = if_id.insn.r.rd;
        dec.wr_en       = 1'b1;
        dec.alu_op      = ALU_ADD;
        dec.imm         = {{16{if_id.insn.i.imm[15]}}, if_id.insn.i.imm};
        dec.shamt       = if_id.insn.r.shamt;
        dec.jump_target = {if_id.pc_plus4[31:28], if_id.insn.j.target, 2'b00};
        case (if_id.insn.r.opcode)
            OP_SPECIAL: begin
                case (if_id.insn.r.funct)
                    FN_ADD, FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:          dec.alu_op = ALU_AND;
                    FN_OR:           dec.alu_op = ALU_OR;
                    FN_XOR:          dec.alu_op = ALU_XOR;
                    FN_SLT:          dec.alu_op = ALU_SLT;
                    FN_SLL:          dec.alu_op = ALU_SLL;
                    FN_SRL:          dec.alu_op = ALU_SRL;
                    FN_SRA:          dec.alu_op = ALU_SRA;
                    default:         dec.illegal = 1'b1;
                endcase
            end
            OP_J: begin
                dec.is_jump = 1'b1;
                dec.wr_en   = 1'b0;
            end
            OP_BEQ, OP_BNE: begin
                dec.is_branch = 1'b1;
                dec.branch_ne = (if_id.insn.i.opcode == OP_BNE);
                dec.wr_en     = 1'b0;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                // I-type results go to rt
                dec.use_imm = 1'b1;
                dec.dest    = if_id.insn.i.rt;
                case (if_id.insn.i.opcode)
                    OP_SLTI: dec.alu_op = ALU_SLT;
                    OP_ANDI: dec.alu_op = ALU_AND;
                    OP_ORI:  dec.alu_op = ALU_OR;
                    OP_XORI: dec.alu_op = ALU_XOR;
                    OP_LUI:  dec.alu_op = ALU_LUI;
                    default: dec.alu_op = ALU_ADD;
                endcase
                // Logical immediates are zero extended
                if (dec.alu_op inside {ALU_AND, ALU_OR, ALU_XOR}) begin
                    dec.imm = {16'b0, if_id.insn.i.imm};
                end
            end
            default: dec.illegal = 1'b1;
        endcase
        if (dec.illegal || dec.dest == 5'd0) begin
            dec.wr_en = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex       <= dec;
            // Squash on redirect or halt from EX
            id_ex.valid <= dec.valid && running && !flush;
        end
    end

endmodule

// File: logic/reg_file.sv
////////////////////
// 31 GPRs plus hardwired r0, reads see the write of the same cycle
////////////////////
module reg_file
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs_num,
    input  logic [4:0]      rt_num,
    input  wb_trace_t       wb,
    output logic [XLEN-1:0] rs_val,
    output logic [XLEN-1:0] rt_val
);

    logic [XLEN-1:0] regs [31:1];

    // Write-through read ports, r0 reads as zero
    assign rs_val = (rs_num == 5'd0)                ? '0
                  : (wb.valid && wb.dest == rs_num) ? wb.value
                  :                                   regs[rs_num];
    assign rt_val = (rt_num == 5'd0)                ? '0
                  : (wb.valid && wb.dest == rt_num) ? wb.value
                  :                                   regs[rt_num];

    // Registers start at zero so programs see a known state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.dest] <= wb.value;
        end
    end

endmodule

// File: logic/execute.sv
////////////////////
// Forwarding, ALU, branch resolution and EX/WB register
// Branches compare operands directly, no delay slot
////////////////////
module execute
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  id_ex_t          id_ex,
    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc,
    output logic            halt,
    output wb_trace_t       wb
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rt_fwd;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic            taken;

    ////////////////////
    // Operand bypass from EX/WB
    ////////////////////
    // wb.valid already implies dest is not r0
    assign op_a   = (wb.valid && wb.dest == id_ex.rs) ? wb.value : id_ex.rs_val;
    assign rt_fwd = (wb.valid && wb.dest == id_ex.rt) ? wb.value : id_ex.rt_val;
    assign op_b   = id_ex.use_imm ? id_ex.imm : rt_fwd;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            // Shifts act on rt by the shamt field
            ALU_SLL: result = op_b << id_ex.shamt;
            ALU_SRL: result = op_b >> id_ex.shamt;
            ALU_SRA: result = $signed(op_b) >>> id_ex.shamt;
            ALU_LUI: result = {id_ex.imm[15:0], 16'b0};
            default: result = '0;
        endcase
    end

    ////////////////////
    // Control transfer
    ////////////////////
    assign taken    = id_ex.is_branch && ((op_a == rt_fwd) != id_ex.branch_ne);
    assign redirect = id_ex.valid && (taken || id_ex.is_jump);

    // Branch offset is in words relative to PC+4
    assign redirect_pc = id_ex.is_jump ? id_ex.jump_target
                                       : id_ex.pc_plus4 + {id_ex.imm[XLEN-3:0], 2'b00};

    // One cycle only, ID/EX is flushed behind it
    assign halt = id_ex.valid && id_ex.illegal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            // wr_en is already low for illegal words and r0
            wb.valid <= id_ex.valid && id_ex.wr_en;
            wb.dest  <= id_ex.dest;
            wb.value <= result;
        end
    end

endmodule

// File: logic/cpu_top.sv
////////////////////
// MIPS-32 subset core, IF / ID / EX / WB
// Load program with load_mode high, trace shows each register write
////////////////////
module cpu_top
    import cpu_pkg::*;
#(
    parameter int IMEM_ADDR_W = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load_mode,
    input  load_req_t load,
    output wb_trace_t trace,
    output logic      running,
    output logic      halted
);

    logic                   halt;
    logic                   redirect;
    logic [XLEN-1:0]        redirect_pc;
    logic [IMEM_ADDR_W-1:0] fetch_addr;
    insn_t                  fetch_insn;
    if_id_t                 if_id;
    id_ex_t                 id_ex;
    logic [4:0]             rs_num;
    logic [4:0]             rt_num;
    logic [XLEN-1:0]        rs_val;
    logic [XLEN-1:0]        rt_val;

    run_ctrl run_ctrl_i (
        .clk, .rst_n, .load_mode, .halt, .running, .halted
    );

    fetch_pc #(.IMEM_ADDR_W(IMEM_ADDR_W)) fetch_pc_i (
        .clk, .rst_n, .running, .redirect, .redirect_pc,
        .fetch_insn, .fetch_addr, .if_id
    );

    // Loader writes are locked out while running
    insn_mem #(.IMEM_ADDR_W(IMEM_ADDR_W)) insn_mem_i (
        .clk, .load, .load_enable(~running), .addr(fetch_addr), .insn(fetch_insn)
    );

    decoder decoder_i (
        .clk, .rst_n, .running, .flush(redirect | halt), .if_id,
        .rs_val, .rt_val, .rs_num, .rt_num, .id_ex
    );

    // The EX/WB entry is both the write port and the trace
    reg_file reg_file_i (
        .clk, .rst_n, .rs_num, .rt_num, .wb(trace), .rs_val, .rt_val
    );

    execute execute_i (
        .clk, .rst_n, .id_ex, .redirect, .redirect_pc, .halt, .wb(trace)
    );

endmodule

// File: verif/cpu_sva.sv
////////////////////
// Trace and run-state properties, bound into cpu_top
////////////////////
module cpu_sva
    import cpu_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input wb_trace_t trace,
    input logic      running,
    input logic      halted
);

    // r0 writes are dropped in decode
    no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        trace.valid |-> trace.dest != 5'd0)
        else $error("register write to r0 shown on trace");

    // RUN is entered only from LOAD once the loader lets go
    run_entry: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(running) |-> $past(!load_mode_low_ok(halted)))
        else $error("core started running from the wrong state");

    // The illegal word and everything behind it write nothing
    quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(halted) |-> !trace.valid [*3])
        else $error("register write after halt");

    function automatic logic load_mode_low_ok(input logic was_halted);
        return was_halted;
    endfunction

endmodule

bind cpu_top cpu_sva cpu_sva_i (.clk, .rst_n, .trace, .running, .halted);

// File: verif/cpu_tb.sv
////////////////////
// Directed and random programs, each ends in an illegal word
// Model registers carry over between programs, there is one reset only
////////////////////
module cpu_tb
    import cpu_pkg::*;
();

    localparam int IMEM_ADDR_W = 8;
    localparam logic [31:0] ILLEGAL_WORD = 32'hfc00_0000;

    logic      clk;
    logic      rst_n;
    logic      load_mode;
    load_req_t load;
    wb_trace_t trace;
    logic      running;
    logic      halted;

    // Program being built, memory mirror and model state
    logic [31:0] code [$];
    logic [31:0] prog [2**IMEM_ADDR_W];
    logic [31:0] mregs [32];
    wb_trace_t   expq [$];
    integer      seed;
    int          cycles;
    int          budget;

    funct_e  alu_fns [11] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
                              FN_XOR, FN_SLT, FN_SLL, FN_SRL, FN_SRA};
    opcode_e imm_ops [7]  = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    cpu_top #(.IMEM_ADDR_W(IMEM_ADDR_W)) dut_i (
        .clk, .rst_n, .load_mode, .load, .trace, .running, .halted
    );

    always #2 clk = ~clk;

    ////////////////////
    // Program encoders
    ////////////////////
    function automatic void alu_r(funct_e fn, int rd, int rs, int rt, int sh);
        r_fields_t f;
        f = '{opcode: OP_SPECIAL, rs: 5'(rs), rt: 5'(rt), rd: 5'(rd), shamt: 5'(sh), funct: fn};
        code.push_back(f);
    endfunction

    // Also used for BEQ and BNE, imm is then the word offset
    function automatic void alu_i(opcode_e op, int rt, int rs, int imm);
        i_fields_t f;
        f = '{opcode: op, rs: 5'(rs), rt: 5'(rt), imm: 16'(imm)};
        code.push_back(f);
    endfunction

    function automatic void jump_to(int word_idx);
        j_fields_t f;
        f = '{opcode: OP_J, target: 26'(word_idx)};
        code.push_back(f);
    endfunction

    function automatic int rand_below(int span);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % span;
    endfunction

    ////////////////////
    // ISA model
    ////////////////////
    // Runs the loaded image from PC 0 and queues every register write
    function automatic void build_expected();
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [4:0]  dst;
        logic        wr;
        logic        stop;
        int          steps;
        pc = '0;
        stop = 1'b0;
        steps = 0;
        while (!stop && steps < 4096) begin
            w = prog[pc[IMEM_ADDR_W+1:2]];
            a = mregs[w[25:21]];
            b = mregs[w[20:16]];
            sx = {{16{w[15]}}, w[15:0]};
            zx = {16'h0, w[15:0]};
            next_pc = pc + 32'd4;
            dst = w[20:16];
            wr = 1'b1;
            res = '0;
            case (w[31:26])
                6'h00: begin
                    dst = w[15:11];
                    case (w[5:0])
                        6'h20, 6'h21: res = a + b;
                        6'h22, 6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h26: res = a ^ b;
                        6'h2a: res = {31'b0, $signed(a) < $signed(b)};
                        6'h00: res = b << w[10:6];
                        6'h02: res = b >> w[10:6];
                        6'h03: res = $signed(b) >>> w[10:6];
                        default: stop = 1'b1;
                    endcase
                end
                // J keeps the top PC+4 nibble
                6'h02: begin
                    wr = 1'b0;
                    next_pc = {next_pc[31:28], w[25:0], 2'b00};
                end
                6'h04: begin
                    wr = 1'b0;
                    if (a == b) next_pc = next_pc + (sx << 2);
                end
                6'h05: begin
                    wr = 1'b0;
                    if (a != b) next_pc = next_pc + (sx << 2);
                end
                6'h08, 6'h09: res = a + sx;
                6'h0a: res = {31'b0, $signed(a) < $signed(sx)};
                6'h0c: res = a & zx;
                6'h0d: res = a | zx;
                6'h0e: res = a ^ zx;
                6'h0f: res = {w[15:0], 16'h0};
                default: stop = 1'b1;
            endcase
            if (!stop && wr && dst != 5'd0) begin
                mregs[dst] = res;
                expq.push_back('{valid: 1'b1, dest: dst, value: res});
            end
            pc = next_pc;
            steps++;
        end
    endfunction

    ////////////////////
    // Programs
    ////////////////////
    // Every ALU form, dependent pairs at distance one and two
    task automatic build_alu_program();
        alu_i(OP_ADDI, 1, 0, 16'h7fff);
        alu_i(OP_ADDIU, 2, 0, 16'h8001);
        alu_r(FN_ADD, 3, 1, 2, 0);
        alu_r(FN_ADDU, 4, 3, 1, 0);
        alu_r(FN_SUB, 5, 4, 2, 0);
        alu_r(FN_SUBU, 6, 2, 5, 0);
        alu_r(FN_AND, 7, 6, 1, 0);
        alu_r(FN_OR, 8, 7, 2, 0);
        alu_r(FN_XOR, 9, 8, 3, 0);
        alu_r(FN_SLT, 10, 2, 1, 0);
        alu_r(FN_SLT, 11, 1, 2, 0);
        alu_r(FN_SLL, 12, 0, 2, 4);
        alu_r(FN_SRL, 13, 0, 2, 3);
        alu_r(FN_SRA, 14, 0, 2, 3);
        alu_i(OP_SLTI, 15, 2, 16'hffff);
        alu_i(OP_ANDI, 16, 2, 16'hf0f0);
        alu_i(OP_ORI, 17, 1, 16'h8000);
        alu_i(OP_XORI, 18, 2, 16'hffff);
        alu_i(OP_LUI, 19, 0, 16'hdead);
        alu_i(OP_ORI, 19, 19, 16'hbeef);
        alu_r(FN_ADD, 0, 1, 1, 0);
        alu_r(FN_ADD, 20, 19, 0, 0);
        alu_r(FN_SLL, 0, 0, 0, 0);
        alu_r(FN_ADD, 21, 20, 20, 0);
        code.push_back(ILLEGAL_WORD);
    endtask

    // Taken and not-taken branches, then a J over one word
    task automatic build_branch_program();
        alu_i(OP_ADDI, 1, 0, 5);
        alu_i(OP_ADDI, 2, 0, 5);
        alu_i(OP_BEQ, 2, 1, 2);
        alu_i(OP_ADDI, 3, 0, 1);
        alu_i(OP_ADDI, 3, 0, 2);
        alu_i(OP_BNE, 2, 1, 1);
        alu_i(OP_ADDI, 4, 0, 3);
        alu_i(OP_BEQ, 0, 1, 1);
        alu_i(OP_ADDI, 5, 0, 4);
        alu_i(OP_BNE, 0, 1, 1);
        alu_i(OP_ADDI, 6, 0, 9);
        jump_to(13);
        alu_i(OP_ADDI, 7, 0, 7);
        alu_i(OP_ADDI, 8, 0, 8);
        code.push_back(ILLEGAL_WORD);
    endtask

    // Unknown SPECIAL function stops the core, later words never write
    task automatic build_halt_program();
        alu_i(OP_ADDI, 1, 1, 1);
        alu_r(funct_e'(6'h08), 2, 1, 1, 0);
        alu_i(OP_ADDI, 2, 0, 7);
        alu_i(OP_ADDI, 3, 0, 9);
    endtask

    task automatic build_random_program();
        int     n;
        int     i;
        int     kind;
        funct_e fn;
        n = 8 + rand_below(17);
        for (i = 0; i < n; i++) begin
            kind = rand_below(10);
            fn = alu_fns[rand_below(11)];
            if (kind < 4 && fn inside {FN_SLL, FN_SRL, FN_SRA}) begin
                alu_r(fn, rand_below(8), 0, rand_below(8), rand_below(32));
            end else if (kind < 4) begin
                alu_r(fn, rand_below(8), rand_below(8), rand_below(8), 0);
            end else if (kind < 8) begin
                alu_i(imm_ops[rand_below(7)], rand_below(8), rand_below(8), rand_below(65536));
            end else if (kind < 9) begin
                // Forward target, at most the closing illegal word
                alu_i(rand_below(2) ? OP_BNE : OP_BEQ, rand_below(8), rand_below(8),
                      rand_below(n - i));
            end else begin
                jump_to(i + 1 + rand_below(n - i));
            end
        end
        code.push_back(ILLEGAL_WORD);
    endtask

    ////////////////////
    // Load, run, check
    ////////////////////
    task automatic check_run_state(input logic exp_running, input logic exp_halted,
                                   input string what);
        assert (running == exp_running && halted == exp_halted) else begin
            $display("The core did not %s, running is %b and halted is %b",
                     what, running, halted);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic run_program();
        int i;
        budget += 6 * code.size() + 40;
        @(negedge clk);
        load_mode = 1'b1;
        @(negedge clk);
        check_run_state(1'b0, 1'b0, "return to load mode");
        for (i = 0; i < code.size(); i++) begin
            @(negedge clk);
            load = '{we: 1'b1, addr: 32'(i), data: code[i]};
            prog[i] = code[i];
        end
        @(negedge clk);
        load = '0;
        build_expected();
        load_mode = 1'b0;
        @(negedge clk);
        check_run_state(1'b1, 1'b0, "start running");
        while (!halted) @(negedge clk);
        assert (expq.size() == 0) else begin
            $display("The core halted while %0d register writes were still expected",
                     expq.size());
            $display("Some tests failed");
            $fatal(1);
        end
        repeat (3) @(negedge clk);
        code.delete();
    endtask

    // Trace checker, outputs settle well before the falling edge
    always @(negedge clk) begin : compare_writes
        wb_trace_t exp_w;
        if (rst_n && trace.valid) begin
            assert (expq.size() != 0) begin
                exp_w = expq.pop_front();
                assert (trace.dest == exp_w.dest && trace.value == exp_w.value) else begin
                    $display("Fail at time %0t: expected r%0d = %h, got r%0d = %h",
                             $time, exp_w.dest, exp_w.value, trace.dest, trace.value);
                    $display("Some tests failed");
                    $fatal(1);
                end
            end else begin
                $display("The core wrote r%0d when no register write was expected", trace.dest);
                $display("Some tests failed");
                $fatal(1);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > budget) begin
            $display("Timeout after %0d cycles, the core never finished its program", cycles);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    initial begin
        seed = 82094;
        clk = 1'b0;
        rst_n = 1'b0;
        load_mode = 1'b1;
        load = '0;
        cycles = 0;
        budget = 20;
        foreach (mregs[k]) mregs[k] = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        build_alu_program();
        run_program();
        build_branch_program();
        run_program();
        build_halt_program();
        run_program();
        repeat (20) begin
            build_random_program();
            run_program();
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// File: filelist.f
logic/cpu_pkg.sv
logic/run_ctrl.sv
logic/fetch_pc.sv
logic/insn_mem.sv
logic/decoder.sv
logic/reg_file.sv
logic/execute.sv
logic/cpu_top.sv
verif/cpu_sva.sv
verif/cpu_tb.sv
